// File: logic/cachePkg.sv
package cachePkg;

  // address and data widths
  localparam int ADDR_W = 32;
  localparam int XLEN = 64;

  // cache geometry, 2 ways of 64 sets with 32 byte lines
  localparam int OFFSET_W = 5;
  localparam int INDEX_W = 6;
  localparam int TAG_W = 21;
  localparam int NUM_SETS = 64;
  localparam int NUM_WAYS = 2;
  localparam int LINE_W = 4 * XLEN;

  typedef logic [ADDR_W-1:0] addrT;
  typedef logic [XLEN-1:0] wordT;
  typedef logic [TAG_W-1:0] tagT;
  typedef logic [INDEX_W-1:0] indexT;
  typedef logic [LINE_W-1:0] lineT;

  // one bit per way
  typedef logic [NUM_WAYS-1:0] wayMaskT;

  // lookup controller states
  typedef enum logic [1:0] {
    idle,
    compare,
    missWait,
    replay
  } ctrlStateT;

endpackage

// File: logic/memBusPkg.sv
package memBusPkg;

  // a line arrives as four 64 bit beats, lowest word first
  localparam int BEATS_PER_LINE = 4;
  localparam int BEAT_CNT_W = 2;

  // request credit counter
  typedef logic [1:0] creditCntT;

  // most credits the refill unit holds at once
  localparam creditCntT MAX_CREDITS = 2'd2;

endpackage

// File: logic/cacheArrays.sv
`timescale 1ns/1ps

module cacheArrays (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              rdEn_i,
  input  cachePkg::indexT   rdIndex_i,
  input  logic              wrEn_i,
  input  cachePkg::wayMaskT wrWay_i,
  input  cachePkg::indexT   wrIndex_i,
  input  cachePkg::tagT     wrTag_i,
  input  cachePkg::lineT    wrLine_i,
  output cachePkg::tagT     tag0_o,
  output cachePkg::tagT     tag1_o,
  output cachePkg::wayMaskT valid_o,
  output cachePkg::lineT    line0_o,
  output cachePkg::lineT    line1_o
);

  cachePkg::wayMaskT validBits [cachePkg::NUM_SETS];
  logic              sameIndex;

  // write and read hit the same set this cycle
  assign sameIndex = wrEn_i && (wrIndex_i == rdIndex_i);

  for (genvar w = 0; w < cachePkg::NUM_WAYS; w++) begin : gWay
    cachePkg::tagT  tagMem  [cachePkg::NUM_SETS];
    cachePkg::lineT dataMem [cachePkg::NUM_SETS];
    cachePkg::tagT  rdTag;
    cachePkg::lineT rdLine;
    logic           wayWr;

    assign wayWr = wrEn_i && wrWay_i[w];

    always_ff @(posedge clk) begin
      if (wayWr) begin
        tagMem[wrIndex_i] <= wrTag_i;
        dataMem[wrIndex_i] <= wrLine_i;
      end
      if (rdEn_i) begin
        // new contents win over the stored ones
        if (wayWr && sameIndex) begin
          rdTag <= wrTag_i;
          rdLine <= wrLine_i;
        end else begin
          rdTag <= tagMem[rdIndex_i];
          rdLine <= dataMem[rdIndex_i];
        end
      end
    end
  end

  assign tag0_o = gWay[0].rdTag;
  assign tag1_o = gWay[1].rdTag;
  assign line0_o = gWay[0].rdLine;
  assign line1_o = gWay[1].rdLine;

  // valid bits in flops so reset can clear every set
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int s = 0; s < cachePkg::NUM_SETS; s++) begin
        validBits[s] <= '0;
      end
      valid_o <= '0;
    end else begin
      if (wrEn_i) begin
        validBits[wrIndex_i] <= validBits[wrIndex_i] | wrWay_i;
      end
      if (rdEn_i) begin
        valid_o <= validBits[rdIndex_i] | (sameIndex ? wrWay_i : '0);
      end
    end
  end

endmodule

// File: logic/refillUnit.sv
`timescale 1ns/1ps

module refillUnit (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              missStart_i,
  input  cachePkg::addrT    missAddr_i,
  input  cachePkg::wayMaskT validWays_i,
  input  logic              memCredit_i,
  output logic              memReqValid_o,
  output cachePkg::addrT    memReqAddr_o,
  input  logic              memDataValid_i,
  input  cachePkg::wordT    memData_i,
  input  logic              memLast_i,
  output logic              lineWrEn_o,
  output cachePkg::wayMaskT wrWay_o,
  output cachePkg::indexT   wrIndex_o,
  output cachePkg::tagT     wrTag_o,
  output cachePkg::lineT    wrLine_o,
  output logic              refillDone_o
);

  memBusPkg::creditCntT             creditCnt;
  logic                             reqPending;
  logic                             inFlight;
  logic [memBusPkg::BEAT_CNT_W-1:0] beatCnt;
  logic [7:0]                       lfsr;
  cachePkg::addrT                   lineAddr;
  cachePkg::wayMaskT                victim;
  cachePkg::lineT                   lineBuf;
  logic                             beatIn;
  logic                             lastBeat;

  // request waits here until a credit shows up
  assign memReqValid_o = reqPending && (creditCnt != '0);
  assign memReqAddr_o = lineAddr;

  assign beatIn = memDataValid_i && inFlight;
  assign lastBeat = memLast_i ||
                    (beatCnt == memBusPkg::BEAT_CNT_W'(memBusPkg::BEATS_PER_LINE - 1));

  // last beat goes straight into the write, earlier ones come from the buffer
  assign lineWrEn_o = beatIn && lastBeat;
  assign refillDone_o = lineWrEn_o;
  assign wrWay_o = victim;
  assign wrIndex_o = lineAddr[cachePkg::OFFSET_W +: cachePkg::INDEX_W];
  assign wrTag_o = lineAddr[cachePkg::ADDR_W-1 -: cachePkg::TAG_W];
  assign wrLine_o = {memData_i, lineBuf[cachePkg::LINE_W-1:cachePkg::XLEN]};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      creditCnt <= '0;
      reqPending <= 1'b0;
      inFlight <= 1'b0;
      beatCnt <= '0;
      lfsr <= 8'h01;
    end else begin
      // credit in and request out in one cycle cancel out
      if (memCredit_i && !memReqValid_o) begin
        if (creditCnt != memBusPkg::MAX_CREDITS) begin
          creditCnt <= creditCnt + 1'b1;
        end
      end else if (!memCredit_i && memReqValid_o) begin
        creditCnt <= creditCnt - 1'b1;
      end
      if (missStart_i) begin
        reqPending <= 1'b1;
      end else if (memReqValid_o) begin
        reqPending <= 1'b0;
      end
      if (memReqValid_o) begin
        inFlight <= 1'b1;
      end else if (lineWrEn_o) begin
        inFlight <= 1'b0;
      end
      if (beatIn) begin
        beatCnt <= lastBeat ? '0 : beatCnt + 1'b1;
      end
      // x^8 + x^6 + x^5 + x^4 + 1
      lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
    end
  end

  always_ff @(posedge clk) begin
    if (missStart_i) begin
      lineAddr <= {missAddr_i[cachePkg::ADDR_W-1:cachePkg::OFFSET_W],
                   {cachePkg::OFFSET_W{1'b0}}};
      // prefer an empty way, else random
      if (!validWays_i[0]) begin
        victim <= 2'b01;
      end else if (!validWays_i[1]) begin
        victim <= 2'b10;
      end else begin
        victim <= lfsr[0] ? 2'b10 : 2'b01;
      end
    end
    if (beatIn) begin
      lineBuf <= {memData_i, lineBuf[cachePkg::LINE_W-1:cachePkg::XLEN]};
    end
  end

endmodule

// File: logic/cacheCtrl.sv
`timescale 1ns/1ps

module cacheCtrl (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              valid_i,
  input  cachePkg::addrT    addr_i,
  output logic              addrOk_o,
  output logic              dataOk_o,
  output cachePkg::wordT    rdData_o,
  output logic              rdEn_o,
  output cachePkg::indexT   rdIndex_o,
  input  cachePkg::tagT     tag0_i,
  input  cachePkg::tagT     tag1_i,
  input  cachePkg::wayMaskT valid_i_ways,
  input  cachePkg::lineT    line0_i,
  input  cachePkg::lineT    line1_i,
  output logic              missStart_o,
  output cachePkg::addrT    missAddr_o,
  output cachePkg::wayMaskT validWays_o,
  input  logic              refillDone_i
);

  cachePkg::ctrlStateT state;
  cachePkg::ctrlStateT nextState;
  cachePkg::addrT      reqAddr;
  cachePkg::tagT       reqTag;
  cachePkg::wayMaskT   wayHit;
  cachePkg::lineT      hitLine;
  logic [1:0]          wordSel;
  logic                hit;
  logic                accept;

  assign reqTag = reqAddr[cachePkg::ADDR_W-1 -: cachePkg::TAG_W];

  // tags and valid bits arrive one cycle after the read
  assign wayHit[0] = valid_i_ways[0] && (tag0_i == reqTag);
  assign wayHit[1] = valid_i_ways[1] && (tag1_i == reqTag);
  assign hit = |wayHit;

  // new requests only while idle or behind a hit
  assign addrOk_o = (state == cachePkg::idle) || ((state == cachePkg::compare) && hit);
  assign accept = valid_i && addrOk_o;

  assign dataOk_o = (state == cachePkg::compare) && hit;
  assign missStart_o = (state == cachePkg::compare) && !hit;
  assign missAddr_o = reqAddr;
  assign validWays_o = valid_i_ways;

  // replay rereads the latched set after the refill
  assign rdEn_o = accept || (state == cachePkg::replay);
  assign rdIndex_o = (state == cachePkg::replay) ?
                     reqAddr[cachePkg::OFFSET_W +: cachePkg::INDEX_W] :
                     addr_i[cachePkg::OFFSET_W +: cachePkg::INDEX_W];

  // word within the line, offset bits 4:3
  assign wordSel = reqAddr[cachePkg::OFFSET_W-1 -: 2];
  assign hitLine = wayHit[1] ? line1_i : line0_i;
  assign rdData_o = hitLine[wordSel*cachePkg::XLEN +: cachePkg::XLEN];

  always_comb begin
    nextState = state;
    case (state)
      cachePkg::idle: begin
        if (accept) begin
          nextState = cachePkg::compare;
        end
      end
      cachePkg::compare: begin
        if (!hit) begin
          nextState = cachePkg::missWait;
        end else if (!valid_i) begin
          nextState = cachePkg::idle;
        end
      end
      cachePkg::missWait: begin
        if (refillDone_i) begin
          nextState = cachePkg::replay;
        end
      end
      cachePkg::replay: begin
        nextState = cachePkg::compare;
      end
      default: begin
        nextState = cachePkg::idle;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= cachePkg::idle;
    end else begin
      state <= nextState;
    end
  end

  // held through a miss since nothing is accepted then
  always_ff @(posedge clk) begin
    if (accept) begin
      reqAddr <= addr_i;
    end
  end

endmodule

// File: logic/cacheTop.sv
`timescale 1ns/1ps

module cacheTop (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           valid_i,
  input  cachePkg::addrT addr_i,
  output logic           addrOk_o,
  output logic           dataOk_o,
  output cachePkg::wordT rdData_o,
  input  logic           memCredit_i,
  output logic           memReqValid_o,
  output cachePkg::addrT memReqAddr_o,
  input  logic           memDataValid_i,
  input  cachePkg::wordT memData_i,
  input  logic           memLast_i
);

  // array read path
  logic              rdEn;
  cachePkg::indexT   rdIndex;
  cachePkg::tagT     tag0;
  cachePkg::tagT     tag1;
  cachePkg::wayMaskT validWays;
  cachePkg::lineT    line0;
  cachePkg::lineT    line1;

  // miss handoff and line write
  logic              missStart;
  cachePkg::addrT    missAddr;
  cachePkg::wayMaskT missValid;
  logic              lineWrEn;
  cachePkg::wayMaskT wrWay;
  cachePkg::indexT   wrIndex;
  cachePkg::tagT     wrTag;
  cachePkg::lineT    wrLine;
  logic              refillDone;

  cacheCtrl uCtrl (
    .clk(clk), .rst_n(rst_n),
    .valid_i(valid_i), .addr_i(addr_i), .addrOk_o(addrOk_o),
    .dataOk_o(dataOk_o), .rdData_o(rdData_o),
    .rdEn_o(rdEn), .rdIndex_o(rdIndex),
    .tag0_i(tag0), .tag1_i(tag1), .valid_i_ways(validWays),
    .line0_i(line0), .line1_i(line1),
    .missStart_o(missStart), .missAddr_o(missAddr), .validWays_o(missValid),
    .refillDone_i(refillDone)
  );

  cacheArrays uArrays (
    .clk(clk), .rst_n(rst_n),
    .rdEn_i(rdEn), .rdIndex_i(rdIndex),
    .wrEn_i(lineWrEn), .wrWay_i(wrWay), .wrIndex_i(wrIndex),
    .wrTag_i(wrTag), .wrLine_i(wrLine),
    .tag0_o(tag0), .tag1_o(tag1), .valid_o(validWays),
    .line0_o(line0), .line1_o(line1)
  );

  refillUnit uRefill (
    .clk(clk), .rst_n(rst_n),
    .missStart_i(missStart), .missAddr_i(missAddr), .validWays_i(missValid),
    .memCredit_i(memCredit_i), .memReqValid_o(memReqValid_o), .memReqAddr_o(memReqAddr_o),
    .memDataValid_i(memDataValid_i), .memData_i(memData_i), .memLast_i(memLast_i),
    .lineWrEn_o(lineWrEn), .wrWay_o(wrWay), .wrIndex_o(wrIndex),
    .wrTag_o(wrTag), .wrLine_o(wrLine), .refillDone_o(refillDone)
  );

endmodule

// File: tb/cacheProtocol_checker.sv
`timescale 1ns/1ps

module cacheProtocol_checker (
  input logic clk,
  input logic rst_n,
  input logic addrOk_i,
  input logic memCredit_i,
  input logic memReqValid_i,
  input logic memDataValid_i,
  input logic memLast_i
);

  memBusPkg::creditCntT credits;
  logic                 missPending;

  // credits seen on the memory port, saturating like the refill unit
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credits <= '0;
      missPending <= 1'b0;
    end else begin
      if (memCredit_i && !memReqValid_i && credits != memBusPkg::MAX_CREDITS) begin
        credits <= credits + 1'b1;
      end else if (!memCredit_i && memReqValid_i) begin
        credits <= credits - 1'b1;
      end
      if (memReqValid_i) begin
        missPending <= 1'b1;
      end else if (memDataValid_i && memLast_i) begin
        missPending <= 1'b0;
      end
    end
  end

  reqNeedsCredit: assert property (@(posedge clk) disable iff (!rst_n)
    memReqValid_i |-> credits != '0)
    else $error("memory request issued with no credit left");

  reqOneCycle: assert property (@(posedge clk) disable iff (!rst_n)
    memReqValid_i |=> !memReqValid_i)
    else $error("memory request held for more than one cycle");

  // no new reads while the line is on its way
  stallDuringMiss: assert property (@(posedge clk) disable iff (!rst_n)
    missPending |-> !addrOk_i)
    else $error("addrOk_o high while a refill is pending");

endmodule

bind cacheTop cacheProtocol_checker protoChk (
  .clk(clk),
  .rst_n(rst_n),
  .addrOk_i(addrOk_o),
  .memCredit_i(memCredit_i),
  .memReqValid_i(memReqValid_o),
  .memDataValid_i(memDataValid_i),
  .memLast_i(memLast_i)
);

// File: tb/cacheMonitor.sv
`timescale 1ns/1ps

module cacheMonitor (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           valid_i,
  input  cachePkg::addrT addr_i,
  input  logic           addrOk_i,
  input  logic           dataOk_i,
  input  cachePkg::wordT rdData_i,
  input  logic           memReqValid_i,
  input  cachePkg::wordT expData_i,
  output cachePkg::addrT expAddr_o,
  output int             errCnt_o,
  output int             acceptCnt_o,
  output int             dataCnt_o
);

  cachePkg::addrT addrQ[$];
  cachePkg::addrT doneAddr;
  int             cycle;
  int             acceptCycle;
  logic           reqSeen;

  // sampled mid cycle, inputs and outputs both settled
  always @(negedge clk) begin
    if (!rst_n) begin
      addrQ.delete();
      cycle = 0;
      acceptCycle = 0;
      reqSeen = 1'b0;
      errCnt_o = 0;
      acceptCnt_o = 0;
      dataCnt_o = 0;
      expAddr_o = '0;
    end else begin
      cycle++;
      if (memReqValid_i) begin
        reqSeen = 1'b1;
      end
      if (dataOk_i) begin
        if (addrQ.size() == 0) begin
          $display("dataOk_o pulsed at %0t with no accepted read outstanding", $time);
          errCnt_o++;
        end else begin
          doneAddr = addrQ.pop_front();
          dataCnt_o++;
          if (rdData_i !== expData_i) begin
            $display("ERR %0t: read %h returned %h, expected %h",
                     $time, doneAddr, rdData_i, expData_i);
            errCnt_o++;
          end
          // a hit has no refill in between and takes one cycle
          if (!reqSeen && cycle != acceptCycle + 1) begin
            $display("ERR %0t: hit on %h took %0d cycles, expected 1",
                     $time, doneAddr, cycle - acceptCycle);
            errCnt_o++;
          end
        end
      end
      if (valid_i && addrOk_i) begin
        addrQ.push_back(addr_i);
        acceptCycle = cycle;
        reqSeen = 1'b0;
        acceptCnt_o++;
      end
      // head of the queue is the next read to complete
      if (addrQ.size() > 0) begin
        expAddr_o = addrQ[0];
      end
    end
  end

endmodule

// File: tb/cacheTb.sv
`timescale 1ns/1ps

module cacheTb;

  localparam int ACCEPT_TIMEOUT = 200;
  localparam int DONE_TIMEOUT = 200;

  logic           clk;
  logic           rst_n;
  logic           valid;
  cachePkg::addrT addr;
  logic           addrOk;
  logic           dataOk;
  cachePkg::wordT rdData;
  logic           memCredit;
  logic           memReqValid;
  cachePkg::addrT memReqAddr;
  logic           memDataValid;
  cachePkg::wordT memData;
  logic           memLast;
  cachePkg::addrT expAddr;
  cachePkg::wordT expData;
  int             monErrs;
  int             acceptCnt;
  int             dataCnt;

  // memory model and bookkeeping
  integer         seed;
  int             tbErrs;
  int             reqCount;
  cachePkg::addrT lastReqAddr;
  logic           busy;
  int             beat;
  int             delayLeft;
  int             creditOwed;
  logic           holdCredits;
  cachePkg::addrT batch[$];

  // word address folded with a constant
  function automatic cachePkg::wordT memWord(input cachePkg::addrT a);
    logic [31:0] wa;
    wa = {3'b000, a[cachePkg::ADDR_W-1:3]};
    return {wa ^ 32'h5A5A_C3E1, wa * 32'h9E37_79B9};
  endfunction

  function automatic cachePkg::addrT makeAddr(input int tag, input int idx, input int word);
    return {tag[cachePkg::TAG_W-1:0], idx[cachePkg::INDEX_W-1:0], word[1:0], 3'b000};
  endfunction

  assign expData = memWord(expAddr);

  always #5 clk = ~clk;

  cacheTop UUT (
    .clk(clk), .rst_n(rst_n),
    .valid_i(valid), .addr_i(addr), .addrOk_o(addrOk),
    .dataOk_o(dataOk), .rdData_o(rdData),
    .memCredit_i(memCredit), .memReqValid_o(memReqValid), .memReqAddr_o(memReqAddr),
    .memDataValid_i(memDataValid), .memData_i(memData), .memLast_i(memLast)
  );

  cacheMonitor mon (
    .clk(clk), .rst_n(rst_n),
    .valid_i(valid), .addr_i(addr), .addrOk_i(addrOk),
    .dataOk_i(dataOk), .rdData_i(rdData), .memReqValid_i(memReqValid),
    .expData_i(expData), .expAddr_o(expAddr),
    .errCnt_o(monErrs), .acceptCnt_o(acceptCnt), .dataCnt_o(dataCnt)
  );

  // memory answers after 1 to 6 cycles, beats may have gaps
  always @(posedge clk) begin
    #1;
    memDataValid = 1'b0;
    memLast = 1'b0;
    memCredit = 1'b0;
    if (rst_n) begin
      if (memReqValid) begin
        lastReqAddr = memReqAddr;
        reqCount++;
        busy = 1'b1;
        beat = 0;
        delayLeft = 1 + int'($unsigned($random(seed)) % 6);
      end else if (busy) begin
        if (delayLeft > 0) begin
          delayLeft--;
        end else begin
          memDataValid = 1'b1;
          memData = memWord(lastReqAddr + beat * 8);
          memLast = (beat == memBusPkg::BEATS_PER_LINE - 1);
          if (memLast) begin
            busy = 1'b0;
            creditOwed++;
          end else begin
            beat++;
            delayLeft = int'($unsigned($random(seed)) % 2);
          end
        end
      end
      if (creditOwed > 0 && !holdCredits) begin
        memCredit = 1'b1;
        creditOwed--;
      end
    end
  end

  task automatic abortRun(input string msg);
    $display("%s at time %0t", msg, $time);
    $display("errors: monitor %0d, testbench %0d", monErrs, tbErrs);
    $display("Something failed");
    $finish;
  endtask

  task automatic acceptOne(input cachePkg::addrT a, output int waitCnt);
    logic accepted;
    valid = 1'b1;
    addr = a;
    accepted = 1'b0;
    waitCnt = 0;
    while (!accepted && waitCnt < ACCEPT_TIMEOUT) begin
      @(negedge clk);
      accepted = addrOk;
      @(posedge clk);
      #1;
      waitCnt++;
    end
    if (!accepted) begin
      abortRun("read request was never accepted");
    end
  endtask

  task automatic waitDone();
    int waitCnt;
    waitCnt = 0;
    while (dataCnt != acceptCnt && waitCnt < DONE_TIMEOUT) begin
      @(posedge clk);
      #1;
      waitCnt++;
    end
    if (dataCnt != acceptCnt) begin
      abortRun("read data never came back");
    end
  endtask

  // expReqs below zero means any number of refills
  task automatic sendReads(input int expReqs);
    int             startReqs;
    int             waitCnt;
    cachePkg::addrT lineAddr;
    startReqs = reqCount;
    foreach (batch[i]) begin
      acceptOne(batch[i], waitCnt);
      if (expReqs == 0 && waitCnt != 1) begin
        $display("ERR %0t: hit read %h waited %0d cycles for accept", $time, batch[i], waitCnt);
        tbErrs++;
      end
    end
    valid = 1'b0;
    waitDone();
    if (expReqs >= 0 && reqCount - startReqs != expReqs) begin
      $display("ERR %0t: %0d memory requests for reads from %h, expected %0d",
               $time, reqCount - startReqs, batch[0], expReqs);
      tbErrs++;
    end
    lineAddr = batch[0];
    lineAddr[cachePkg::OFFSET_W-1:0] = '0;
    if (expReqs == 1 && batch.size() == 1 && lastReqAddr != lineAddr) begin
      $display("ERR %0t: memory request address %h, expected %h", $time, lastReqAddr, lineAddr);
      tbErrs++;
    end
  endtask

  task automatic readOne(input cachePkg::addrT a, input int expReqs);
    batch.delete();
    batch.push_back(a);
    sendReads(expReqs);
  endtask

  initial begin
    int waitCnt;
    int startReqs;
    int tagSel;
    int idxSel;
    int wordSel;
    seed = 55547;
    clk = 1'b0;
    rst_n = 1'b0;
    valid = 1'b0;
    addr = '0;
    memCredit = 1'b0;
    memDataValid = 1'b0;
    memData = '0;
    memLast = 1'b0;
    tbErrs = 0;
    reqCount = 0;
    lastReqAddr = '0;
    busy = 1'b0;
    beat = 0;
    delayLeft = 0;
    holdCredits = 1'b0;
    // two credits handed out once reset is released
    creditOwed = 2;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    if (!addrOk || dataOk || memReqValid) begin
      $display("ERR %0t: outputs after reset addrOk %b dataOk %b memReqValid %b",
               $time, addrOk, dataOk, memReqValid);
      tbErrs++;
    end
    @(posedge clk);
    #1;

    // first touch of two lines
    readOne(makeAddr(1, 5, 2), 1);
    readOne(makeAddr(2, 6, 1), 1);

    // resident lines, back to back
    batch.delete();
    for (int w = 0; w < 4; w++) begin
      batch.push_back(makeAddr(1, 5, w));
    end
    batch.push_back(makeAddr(2, 6, 3));
    sendReads(0);

    // two tags sharing index 9
    readOne(makeAddr(3, 9, 0), 1);
    readOne(makeAddr(4, 9, 1), 1);
    batch.delete();
    batch.push_back(makeAddr(3, 9, 2));
    batch.push_back(makeAddr(4, 9, 3));
    sendReads(0);

    // third tag evicts one of them
    readOne(makeAddr(5, 9, 0), 1);
    batch.delete();
    for (int t = 3; t < 6; t++) begin
      for (int w = 0; w < 4; w++) begin
        batch.push_back(makeAddr(t, 9, w));
      end
    end
    sendReads(-1);

    // drain both credits, then block the next miss
    holdCredits = 1'b1;
    readOne(makeAddr(6, 12, 0), 1);
    readOne(makeAddr(7, 13, 0), 1);
    startReqs = reqCount;
    acceptOne(makeAddr(8, 14, 1), waitCnt);
    // a second read of the same word stays held on the pipeline side
    repeat (20) begin
      @(negedge clk);
      if (memReqValid || addrOk) begin
        $display("ERR %0t: without credits memReqValid %b addrOk %b", $time, memReqValid, addrOk);
        tbErrs++;
      end
    end
    @(posedge clk);
    #1;
    holdCredits = 1'b0;
    acceptOne(makeAddr(8, 14, 1), waitCnt);
    valid = 1'b0;
    waitDone();
    if (reqCount != startReqs + 1) begin
      $display("ERR %0t: %0d requests after credit release, expected 1",
               $time, reqCount - startReqs);
      tbErrs++;
    end

    // random mix over 8 tags and 4 indexes
    batch.delete();
    repeat (300) begin
      tagSel = 16 + int'($unsigned($random(seed)) % 8);
      idxSel = 20 + int'($unsigned($random(seed)) % 4);
      wordSel = int'($unsigned($random(seed)) % 4);
      batch.push_back(makeAddr(tagSel, idxSel, wordSel));
    end
    sendReads(-1);

    $display("errors: monitor %0d, testbench %0d", monErrs, tbErrs);
    if (monErrs == 0 && tbErrs == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: sources.f
logic/cachePkg.sv
logic/memBusPkg.sv
logic/cacheArrays.sv
logic/refillUnit.sv
logic/cacheCtrl.sv
logic/cacheTop.sv
tb/cacheProtocol_checker.sv
tb/cacheMonitor.sv
tb/cacheTb.sv

// File: run.sh
#!/usr/bin/env bash
# build the cache testbench with Verilator and run it
set -euo pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
  -f sources.f --top-module cacheTb -o cacheSim

./obj_dir/cacheSim | tee sim.log

if grep -q "Something failed" sim.log; then
  echo "simulation reported errors"
  exit 1
fi
echo "simulation finished without errors"
